// ==== rtl/mips_settings.svh ====
/* Shared constants for the single-cycle MIPS core.
   Holds the reset vector, the register count, the opcode and funct
   encodings of the kept instruction set, and the ALU operation codes.
   Included by every block that decodes or executes instructions */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// First fetch address after reset
`define RESET_VECTOR 32'hBFC00000
`define NUM_REGS     32

// Primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0A
`define OP_ANDI  6'h0C
`define OP_ORI   6'h0D
`define OP_XORI  6'h0E
`define OP_LUI   6'h0F
`define OP_LW    6'h23
`define OP_SW    6'h2B

// R-type funct codes, instr[5:0]
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_SRA  6'h03
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2A
`define FN_SLTU 6'h2B

// ALU operation selectors
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_AND  4'd2
`define ALU_OR   4'd3
`define ALU_XOR  4'd4
`define ALU_SLT  4'd5
`define ALU_SLTU 4'd6
`define ALU_SLL  4'd7
`define ALU_SRL  4'd8
`define ALU_SRA  4'd9
`define ALU_LUI  4'd10

`endif

// ==== rtl/mipsPkg.sv ====
/* Types shared by the MIPS core blocks and the testbench.
   Import by wildcard in the module header */
`default_nettype none

package mipsPkg;

  // Data and address word
  typedef logic [31:0] Word;

  // Register number, rs/rt/rd fields
  typedef logic [4:0] RegIndex;

  // Instruction fields
  typedef logic [5:0] Opcode;
  typedef logic [5:0] Funct;

  // ALU operation, see ALU_* macros
  typedef logic [3:0] AluOp;

  // Write-back source and destination selectors
  typedef logic [1:0] WbSel;
  typedef logic [1:0] DstSel;

  localparam WbSel wbAlu  = 2'd0;
  localparam WbSel wbMem  = 2'd1;
  // Return address for jal
  localparam WbSel wbLink = 2'd2;

  localparam DstSel dstRt  = 2'd0;
  localparam DstSel dstRd  = 2'd1;
  localparam DstSel dstR31 = 2'd2;

  // Core run state, halted after a fetch from address zero
  typedef enum logic {
    stRunning,
    stHalted
  } RunState;

endpackage

`default_nettype wire

// ==== rtl/programCounter.sv ====
/* Program counter and run state of the core.
   Loads the next PC on every enabled edge while running. An enabled
   edge that sees PC zero halts the core and freezes the PC.
   running feeds the core's active output */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module programCounter
  import mipsPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic clkEnable,
  input  Word  nextPc,
  output Word  pc,
  output logic running
);

  RunState state;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc    <= `RESET_VECTOR;
      state <= stRunning;
    end
    else if (clkEnable && state == stRunning)
    begin
      // Jump to zero ends the program
      if (pc == '0)
      begin
        state <= stHalted;
      end
      else
      begin
        pc <= nextPc;
      end
    end
  end

  assign running = (state == stRunning);

endmodule

`default_nettype wire

// ==== rtl/controlUnit.sv ====
/* Main decoder of the single-cycle core.
   Turns opcode and funct into datapath control levels. Unknown
   encodings decode to a no-op, and write strobes stay low once halted */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module controlUnit
  import mipsPkg::*;
(
  input  Word   instr,
  input  logic  running,
  output logic  regWrite,
  output logic  aluSrcImm,
  output logic  branch,
  output logic  branchNe,
  output logic  jump,
  output logic  jumpReg,
  output logic  memRead,
  output logic  memWrite,
  output DstSel dstSel,
  output WbSel  wbSel,
  output AluOp  aluOp
);

  Opcode opcode;
  Funct  funct;
  logic  decRegWrite;
  logic  decMemWrite;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb
  begin
    // No-op defaults
    decRegWrite = 1'b0;
    decMemWrite = 1'b0;
    aluSrcImm   = 1'b0;
    branch      = 1'b0;
    branchNe    = 1'b0;
    jump        = 1'b0;
    jumpReg     = 1'b0;
    memRead     = 1'b0;
    dstSel      = dstRt;
    wbSel       = wbAlu;
    aluOp       = `ALU_ADD;
    case (opcode)
      `OP_RTYPE:
      begin
        dstSel      = dstRd;
        decRegWrite = 1'b1;
        case (funct)
          `FN_ADDU: aluOp = `ALU_ADD;
          `FN_SUBU: aluOp = `ALU_SUB;
          `FN_AND:  aluOp = `ALU_AND;
          `FN_OR:   aluOp = `ALU_OR;
          `FN_XOR:  aluOp = `ALU_XOR;
          `FN_SLT:  aluOp = `ALU_SLT;
          `FN_SLTU: aluOp = `ALU_SLTU;
          `FN_SLL:  aluOp = `ALU_SLL;
          `FN_SRL:  aluOp = `ALU_SRL;
          `FN_SRA:  aluOp = `ALU_SRA;
          `FN_JR:
          begin
            // jr writes nothing
            decRegWrite = 1'b0;
            jumpReg     = 1'b1;
          end
          default:  decRegWrite = 1'b0;
        endcase
      end
      `OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI:
      begin
        decRegWrite = 1'b1;
        aluSrcImm   = 1'b1;
        case (opcode)
          `OP_SLTI: aluOp = `ALU_SLT;
          `OP_ANDI: aluOp = `ALU_AND;
          `OP_ORI:  aluOp = `ALU_OR;
          `OP_XORI: aluOp = `ALU_XOR;
          `OP_LUI:  aluOp = `ALU_LUI;
          default:  aluOp = `ALU_ADD;
        endcase
      end
      `OP_LW:
      begin
        decRegWrite = 1'b1;
        aluSrcImm   = 1'b1;
        memRead     = 1'b1;
        wbSel       = wbMem;
      end
      `OP_SW:
      begin
        decMemWrite = 1'b1;
        aluSrcImm   = 1'b1;
      end
      `OP_BEQ, `OP_BNE:
      begin
        branch   = 1'b1;
        branchNe = (opcode == `OP_BNE);
        aluOp    = `ALU_SUB;
      end
      `OP_J:
        jump = 1'b1;
      `OP_JAL:
      begin
        // Link into r31
        jump        = 1'b1;
        decRegWrite = 1'b1;
        dstSel      = dstR31;
        wbSel       = wbLink;
      end
      default:
        decRegWrite = 1'b0;
    endcase
  end

  // Nothing is written once halted
  assign regWrite = decRegWrite & running;
  assign memWrite = decMemWrite & running;

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
/* General register file of the core.
   Two combinational read ports and one write port that commits on
   enabled clock edges. Register 0 reads as zero, register 2 (v0) is
   also tapped out for observation */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module registerFile
  import mipsPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    clkEnable,
  input  logic    writeEnable,
  input  RegIndex readReg1,
  input  RegIndex readReg2,
  input  RegIndex writeReg,
  input  Word     writeData,
  output Word     readData1,
  output Word     readData2,
  output Word     registerV0
);

  Word regs [`NUM_REGS];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    // r0 write is dropped
    else if (clkEnable && writeEnable && writeReg != '0)
    begin
      regs[writeReg] <= writeData;
    end
  end

  // Asynchronous reads, r0 stays zero after reset
  assign readData1 = regs[readReg1];
  assign readData2 = regs[readReg2];

  // v0 tap
  assign registerV0 = regs[2];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
/* Execute stage of the single-cycle core.
   Builds the second operand from rt or the extended immediate, runs
   the arithmetic, logic, shift and compare operations, and decides
   whether a beq or bne is taken */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module alu
  import mipsPkg::*;
(
  input  AluOp aluOp,
  input  logic aluSrcImm,
  input  logic branch,
  input  logic branchNe,
  input  Word  instr,
  input  Word  rsData,
  input  Word  rtData,
  output Word  result,
  output logic branchTaken
);

  logic [15:0] imm;
  logic [4:0]  shamt;
  Word         immExt;
  Word         operandB;
  logic        equal;

  assign imm   = instr[15:0];
  assign shamt = instr[10:6];

  // Immediate extension depends on the operation
  always_comb
  begin
    case (aluOp)
      `ALU_AND, `ALU_OR, `ALU_XOR:
        immExt = {16'b0, imm};
      `ALU_LUI:
        immExt = {imm, 16'b0};
      default:
        immExt = {{16{imm[15]}}, imm};
    endcase
  end

  assign operandB = aluSrcImm ? immExt : rtData;

  always_comb
  begin
    case (aluOp)
      `ALU_ADD:  result = rsData + operandB;
      `ALU_SUB:  result = rsData - operandB;
      `ALU_AND:  result = rsData & operandB;
      `ALU_OR:   result = rsData | operandB;
      `ALU_XOR:  result = rsData ^ operandB;
      `ALU_SLT:  result = {31'b0, $signed(rsData) < $signed(operandB)};
      `ALU_SLTU: result = {31'b0, rsData < operandB};
      // Shifts use rt and the shamt field
      `ALU_SLL:  result = rtData << shamt;
      `ALU_SRL:  result = rtData >> shamt;
      `ALU_SRA:  result = Word'($signed(rtData) >>> shamt);
      // Immediate already placed in the upper half
      `ALU_LUI:  result = operandB;
      default:   result = '0;
    endcase
  end

  // beq and bne compare rs with rt
  assign equal       = (rsData == rtData);
  assign branchTaken = branch & (branchNe ? ~equal : equal);

endmodule

`default_nettype wire

// ==== rtl/nextPcLogic.sv ====
/* Next-PC selection of the single-cycle core.
   Produces PC+4 for linking and chooses between jr, j/jal, a taken
   branch and the sequential address. No delay slot */
`timescale 1ns/100ps
`default_nettype none

module nextPcLogic
  import mipsPkg::*;
(
  input  Word  pc,
  input  Word  instr,
  input  Word  rsData,
  input  logic branchTaken,
  input  logic jump,
  input  logic jumpReg,
  output Word  nextPc,
  output Word  pcPlus4
);

  Word branchTarget;
  Word jumpTarget;

  assign pcPlus4 = pc + 32'd4;

  // Word offset relative to the next instruction
  assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};

  // Stays inside the current 256 MB region
  assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

  always_comb
  begin
    if (jumpReg)
      nextPc = rsData;
    else if (jump)
      nextPc = jumpTarget;
    else if (branchTaken)
      nextPc = branchTarget;
    else
      nextPc = pcPlus4;
  end

endmodule

`default_nettype wire

// ==== rtl/mipsCpuHarvard.sv ====
/* Top level of the single-cycle MIPS-I core, Harvard form.
   Instruction and data ports read combinationally, data writes commit
   on enabled edges. One instruction retires per enabled edge, and
   active falls after the program jumps to address zero */
`timescale 1ns/100ps
`default_nettype none

module mipsCpuHarvard
  import mipsPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic clkEnable,
  output logic active,
  output Word  registerV0,
  output Word  instrAddress,
  input  Word  instrReadData,
  output Word  dataAddress,
  output Word  dataWriteData,
  output logic dataRead,
  output logic dataWrite,
  input  Word  dataReadData
);

  Word     nextPc;
  Word     pcPlus4;
  Word     rsData;
  Word     rtData;
  Word     aluResult;
  Word     writeData;
  RegIndex writeReg;
  logic    regWrite;
  logic    aluSrcImm;
  logic    branch;
  logic    branchNe;
  logic    branchTaken;
  logic    jump;
  logic    jumpReg;
  DstSel   dstSel;
  WbSel    wbSel;
  AluOp    aluOp;

  programCounter pc_i (
    .clk       (clk),
    .reset     (reset),
    .clkEnable (clkEnable),
    .nextPc    (nextPc),
    .pc        (instrAddress),
    .running   (active)
  );

  controlUnit control_i (
    .instr     (instrReadData),
    .running   (active),
    .regWrite  (regWrite),
    .aluSrcImm (aluSrcImm),
    .branch    (branch),
    .branchNe  (branchNe),
    .jump      (jump),
    .jumpReg   (jumpReg),
    .memRead   (dataRead),
    .memWrite  (dataWrite),
    .dstSel    (dstSel),
    .wbSel     (wbSel),
    .aluOp     (aluOp)
  );

  // Destination register choice
  always_comb
  begin
    case (dstSel)
      dstRd:   writeReg = instrReadData[15:11];
      dstR31:  writeReg = RegIndex'(31);
      default: writeReg = instrReadData[20:16];
    endcase
  end

  registerFile regs_i (
    .clk         (clk),
    .reset       (reset),
    .clkEnable   (clkEnable),
    .writeEnable (regWrite),
    .readReg1    (instrReadData[25:21]),
    .readReg2    (instrReadData[20:16]),
    .writeReg    (writeReg),
    .writeData   (writeData),
    .readData1   (rsData),
    .readData2   (rtData),
    .registerV0  (registerV0)
  );

  alu alu_i (
    .aluOp       (aluOp),
    .aluSrcImm   (aluSrcImm),
    .branch      (branch),
    .branchNe    (branchNe),
    .instr       (instrReadData),
    .rsData      (rsData),
    .rtData      (rtData),
    .result      (aluResult),
    .branchTaken (branchTaken)
  );

  nextPcLogic nextPc_i (
    .pc          (instrAddress),
    .instr       (instrReadData),
    .rsData      (rsData),
    .branchTaken (branchTaken),
    .jump        (jump),
    .jumpReg     (jumpReg),
    .nextPc      (nextPc),
    .pcPlus4     (pcPlus4)
  );

  // Loads and stores address through the ALU sum
  assign dataAddress   = aluResult;
  assign dataWriteData = rtData;

  // Write-back source
  always_comb
  begin
    case (wbSel)
      wbMem:   writeData = dataReadData;
      wbLink:  writeData = pcPlus4;
      default: writeData = aluResult;
    endcase
  end

endmodule

`default_nettype wire

// ==== tests/mipsCpuHarvard_sva.sv ====
/* Assertions on the MIPS core ports.
   Bound into every mipsCpuHarvard instance by the testbench top.
   Covers reset state, PC alignment, stall hold and halt behavior */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module mipsCpuHarvardSva
  import mipsPkg::*;
(
  input logic clk,
  input logic reset,
  input logic clkEnable,
  input logic active,
  input Word  instrAddress,
  input Word  registerV0,
  input logic dataWrite
);

  // First cycle out of reset
  assert property (@(posedge clk)
    reset |=> (instrAddress == `RESET_VECTOR) && active && !dataWrite)
    else $error("Core not in reset state after reset");

  assert property (@(posedge clk) disable iff (reset)
    instrAddress[1:0] == 2'b00)
    else $error("Fetch address not word aligned");

  // Stalled edge keeps the PC
  assert property (@(posedge clk) disable iff (reset)
    !clkEnable |=> $stable(instrAddress))
    else $error("PC moved on a stalled edge");

  // Halted core stays frozen
  assert property (@(posedge clk) disable iff (reset)
    !active |=> !active && $stable(instrAddress) && $stable(registerV0))
    else $error("Halted core changed state");

endmodule

`default_nettype wire

// ==== tests/cpuChecker.sv ====
/* Result checker for the MIPS core testbench.
   Watches the core ports, waits for halt with a timeout and compares
   values against expectations handed in by the testbench top.
   errorCount holds the number of failed checks */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module cpuChecker
  import mipsPkg::*;
(
  input logic clk,
  input logic active,
  input Word  instrAddress,
  input Word  registerV0,
  input logic dataRead,
  input logic dataWrite
);

  int errorCount = 0;

  task automatic compareWord(input string testName, input string what,
                             input Word expected, input Word actual);
    if (expected !== actual)
    begin
      errorCount++;
      $display("Error %s %s: expected %h, actual %h", testName, what, expected, actual);
    end
  endtask

  // Called right after reset is released
  task automatic checkResetState(input string testName);
    @(negedge clk);
    compareWord(testName, "instrAddress", `RESET_VECTOR, instrAddress);
    if (!active || dataWrite || dataRead)
    begin
      errorCount++;
      $display("Test %s: core not active or accessing memory after reset", testName);
    end
  endtask

  task automatic waitForHalt(input string testName, input Word expectedV0);
    int cycles;
    cycles = 0;
    while (active && cycles < 500)
    begin
      @(negedge clk);
      cycles++;
    end
    if (active)
    begin
      errorCount++;
      $display("Test %s: core did not halt within 500 cycles", testName);
    end
    else
    begin
      compareWord(testName, "v0", expectedV0, registerV0);
      // Halt must stick
      repeat (5)
      begin
        @(negedge clk);
        if (active)
        begin
          errorCount++;
          $display("Test %s: active rose again after halt", testName);
        end
      end
    end
  endtask

endmodule

`default_nettype wire

// ==== tests/mipsCpuHarvardTb.sv ====
/* Testbench top for the single-cycle MIPS core.
   Models instruction ROM and data RAM, runs a table of small programs
   once without stalls and once with random clkEnable stalls, and
   prints the regression result */
`timescale 1ns/100ps
`default_nettype none

`include "mips_settings.svh"

module mipsCpuHarvardTb
  import mipsPkg::*;
;

  localparam int NUM_TESTS = 5;

  logic clk;
  logic reset;
  logic clkEnable = 1'b0;
  logic stallMode = 1'b0;
  logic active;
  logic dataRead;
  logic dataWrite;
  Word  registerV0;
  Word  instrAddress;
  Word  instrReadData;
  Word  dataAddress;
  Word  dataWriteData;
  Word  dataReadData;

  Word rom [16];
  Word ram [16];

  // Program table
  string testNames [NUM_TESTS];
  Word   programs [NUM_TESTS][10];
  Word   initData [NUM_TESTS];
  Word   expectedV0 [NUM_TESTS];
  int    memIndex [NUM_TESTS];
  Word   expectedMem [NUM_TESTS];

  mipsCpuHarvard dut_i (
    .clk           (clk),
    .reset         (reset),
    .clkEnable     (clkEnable),
    .active        (active),
    .registerV0    (registerV0),
    .instrAddress  (instrAddress),
    .instrReadData (instrReadData),
    .dataAddress   (dataAddress),
    .dataWriteData (dataWriteData),
    .dataRead      (dataRead),
    .dataWrite     (dataWrite),
    .dataReadData  (dataReadData)
  );

  cpuChecker checker_i (
    .clk          (clk),
    .active       (active),
    .instrAddress (instrAddress),
    .registerV0   (registerV0),
    .dataRead     (dataRead),
    .dataWrite    (dataWrite)
  );

  bind mipsCpuHarvard mipsCpuHarvardSva sva_i (
    .clk          (clk),
    .reset        (reset),
    .clkEnable    (clkEnable),
    .active       (active),
    .instrAddress (instrAddress),
    .registerV0   (registerV0),
    .dataWrite    (dataWrite)
  );

  // ROM mapped at the reset vector, zero elsewhere
  assign instrReadData = (instrAddress[31:6] == `RESET_VECTOR >> 6) ?
                         rom[instrAddress[5:2]] : '0;
  // RAM answers only while the core reads
  assign dataReadData  = dataRead ? ram[dataAddress[5:2]] : '0;

  always @(posedge clk)
  begin
    if (dataWrite && clkEnable)
    begin
      ram[dataAddress[5:2]] <= dataWriteData;
    end
  end

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Roughly one stalled cycle in four
  always @(posedge clk)
  begin
    #10;
    clkEnable <= stallMode ? (($urandom % 4) != 0) : 1'b1;
  end

  function automatic Word rTypeWord(input int rs, input int rt, input int rd,
                                    input int shamt, input logic [5:0] fn);
    rTypeWord = {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
  endfunction

  function automatic Word iTypeWord(input logic [5:0] op, input int rs,
                                    input int rt, input int imm);
    iTypeWord = {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  // Target given as ROM word number
  function automatic Word jumpWord(input logic [5:0] op, input int wordNum);
    Word target;
    target = `RESET_VECTOR + Word'(wordNum * 4);
    jumpWord = {op, target[27:2]};
  endfunction

  task automatic fillTable();
    Word jrZero;
    jrZero = rTypeWord(0, 0, 0, 0, `FN_JR);
    // v0 = (0x12340000 ^ sra(-5,1)) + slt(-5,3) + sltu(-5,3)
    testNames[0] = "aluArith";
    programs[0] = '{iTypeWord(`OP_ADDIU, 0, 8, -5), iTypeWord(`OP_ADDIU, 0, 9, 3),
                    rTypeWord(8, 9, 10, 0, `FN_SLT), rTypeWord(8, 9, 11, 0, `FN_SLTU),
                    iTypeWord(`OP_LUI, 0, 12, 'h1234), rTypeWord(0, 8, 13, 1, `FN_SRA),
                    rTypeWord(12, 13, 2, 0, `FN_XOR), rTypeWord(10, 11, 10, 0, `FN_ADDU),
                    rTypeWord(2, 10, 2, 0, `FN_ADDU), jrZero};
    expectedV0[0] = 32'hEDCBFFFE;
    // 0xF0FF - (1 + (1 << 8))
    testNames[1] = "aluLogic";
    programs[1] = '{iTypeWord(`OP_ORI, 0, 8, 'hFF00), iTypeWord(`OP_ANDI, 8, 9, 'h0FF0),
                    iTypeWord(`OP_XORI, 9, 9, 'hFFFF), iTypeWord(`OP_ADDIU, 0, 11, -1),
                    rTypeWord(9, 11, 12, 0, `FN_SLTU), iTypeWord(`OP_SLTI, 11, 13, 1),
                    rTypeWord(0, 13, 13, 8, `FN_SLL), rTypeWord(12, 13, 12, 0, `FN_ADDU),
                    rTypeWord(9, 12, 2, 0, `FN_SUBU), jrZero};
    expectedV0[1] = 32'h0000EFFE;
    // Copy word 0 to word 6, read back and add 0x25
    testNames[2] = "memory";
    programs[2] = '{iTypeWord(`OP_ADDIU, 0, 8, 'h10), iTypeWord(`OP_LW, 0, 9, 0),
                    iTypeWord(`OP_SW, 8, 9, 8), iTypeWord(`OP_LW, 0, 10, 'h18),
                    iTypeWord(`OP_ADDIU, 10, 2, 'h25), jrZero,
                    32'h0, 32'h0, 32'h0, 32'h0};
    expectedV0[2] = 32'h0BADF032;
    // Poisoned adds sit after taken branches
    testNames[3] = "branch";
    programs[3] = '{iTypeWord(`OP_ADDIU, 0, 8, 'h40), rTypeWord(0, 8, 2, 2, `FN_SRL),
                    iTypeWord(`OP_BEQ, 8, 0, 1), iTypeWord(`OP_ADDIU, 2, 2, 1),
                    iTypeWord(`OP_BNE, 8, 0, 1), iTypeWord(`OP_ADDIU, 2, 2, 'h100),
                    iTypeWord(`OP_BEQ, 2, 2, 1), iTypeWord(`OP_ADDIU, 2, 2, 'h200),
                    iTypeWord(`OP_BNE, 2, 2, 1), jrZero};
    expectedV0[3] = 32'h00000011;
    // j skips a poison, jal calls word 6 which returns to word 4
    testNames[4] = "jump";
    programs[4] = '{iTypeWord(`OP_ADDIU, 0, 2, 1), jumpWord(`OP_J, 3),
                    iTypeWord(`OP_ADDIU, 2, 2, 'h100), jumpWord(`OP_JAL, 6),
                    iTypeWord(`OP_ADDIU, 2, 2, 'h10), jrZero,
                    iTypeWord(`OP_ADDIU, 2, 2, 2), rTypeWord(31, 0, 0, 0, `FN_JR),
                    32'h0, 32'h0};
    expectedV0[4] = 32'h00000013;
    for (int r = 0; r < NUM_TESTS; r++)
    begin
      initData[r]    = '0;
      memIndex[r]    = -1;
      expectedMem[r] = '0;
    end
    initData[2]    = 32'h0BADF00D;
    memIndex[2]    = 6;
    expectedMem[2] = 32'h0BADF00D;
  endtask

  task automatic loadMemories(input int row);
    for (int i = 0; i < 16; i++)
    begin
      rom[i] = (i < 10) ? programs[row][i] : '0;
      ram[i] = 32'h5A5A0000 | Word'(i * 4);
    end
    ram[0] = initData[row];
  endtask

  task automatic runProgram(input int row);
    @(posedge clk);
    #10;
    reset = 1'b1;
    loadMemories(row);
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;
    checker_i.checkResetState(testNames[row]);
    checker_i.waitForHalt(testNames[row], expectedV0[row]);
    if (memIndex[row] >= 0)
    begin
      checker_i.compareWord(testNames[row], "data RAM", expectedMem[row],
                            ram[memIndex[row]]);
    end
  endtask

  initial
  begin
    void'($urandom(19715));
    reset = 1'b1;
    fillTable();
    loadMemories(0);
    // First pass unstalled, second with random stalls
    for (int pass = 0; pass < 2; pass++)
    begin
      stallMode = (pass == 1);
      for (int row = 0; row < NUM_TESTS; row++)
      begin
        runProgram(row);
      end
    end
    $display("Checks complete, %0d errors", checker_i.errorCount);
    if (checker_i.errorCount == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/mipsPkg.sv
rtl/programCounter.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/nextPcLogic.sv
rtl/mipsCpuHarvard.sv
tests/mipsCpuHarvard_sva.sv
tests/cpuChecker.sv
tests/mipsCpuHarvardTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = mipsCpuHarvardTb
FILELIST  = sim.f
PASS_TEXT = Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf obj_dir
